/* hw/lc3b_isa_pkg.sv */
`default_nettype none

package lc3b_isa_pkg;

	// Data and instruction word
	typedef logic [15:0] lc3b_word;

	// Architectural register number, R0 to R7
	typedef logic [2:0] lc3b_reg;

	typedef logic [3:0] lc3b_opcode;

	// Operate instructions handled by the core
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_not = 4'b1001;

	// Operation carried by a reservation station to the ALU
	typedef enum logic [1:0] {
		alu_add = 2'd0,
		alu_and = 2'd1,
		alu_not = 2'd2
	} alu_op_e;

endpackage

`default_nettype wire

/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	// ROB entry index, also used as the rename tag
	typedef logic [2:0] rob_tag;

	// Reservation station number
	typedef logic [1:0] rs_index;

	// ALU reservation stations in the default build
	localparam int NUM_RS = 3;

endpackage

`default_nettype wire

/* hw/issue_control.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_control #(
	parameter int ROB_DEPTH = 8,
	parameter int RS_COUNT  = ooo_pkg::NUM_RS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_isa_pkg::lc3b_word instr,
	input  logic                  instr_is_new,
	output logic                  issue_stall,
	output lc3b_isa_pkg::lc3b_reg  src1_reg,
	output lc3b_isa_pkg::lc3b_reg  src2_reg,
	input  lc3b_isa_pkg::lc3b_word src1_value,
	input  logic                  src1_busy,
	input  ooo_pkg::rob_tag        src1_tag,
	input  lc3b_isa_pkg::lc3b_word src2_value,
	input  logic                  src2_busy,
	input  ooo_pkg::rob_tag        src2_tag,
	input  logic                  src1_done,
	input  lc3b_isa_pkg::lc3b_word src1_result,
	input  logic                  src2_done,
	input  lc3b_isa_pkg::lc3b_word src2_result,
	input  logic                  rob_full,
	input  ooo_pkg::rob_tag        rob_tail_tag,
	output logic                  rob_alloc,
	output lc3b_isa_pkg::lc3b_reg  rob_dest_reg,
	output logic                  rename_valid,
	output lc3b_isa_pkg::lc3b_reg  rename_reg,
	output ooo_pkg::rob_tag        rename_tag,
	input  logic [RS_COUNT-1:0]   rs_busy,
	output logic                  rs_write,
	output ooo_pkg::rs_index       rs_sel,
	output lc3b_isa_pkg::alu_op_e  rs_op,
	output lc3b_isa_pkg::lc3b_word rs_vj,
	output lc3b_isa_pkg::lc3b_word rs_vk,
	output ooo_pkg::rob_tag        rs_qj,
	output ooo_pkg::rob_tag        rs_qk,
	output logic                  rs_valid_j,
	output logic                  rs_valid_k,
	output ooo_pkg::rob_tag        rs_dest_tag,
	input  logic                  cdb_valid,
	input  ooo_pkg::rob_tag        cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	// Tag bits that address a live ROB entry
	localparam int TAG_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;

	lc3b_opcode opcode;
	lc3b_reg    dest_reg;
	logic       imm_form;
	lc3b_word   imm_value;
	logic       op_legal;
	logic       free_found;
	rs_index    free_sel;
	logic       issue_fire;

	function automatic logic tag_hit(input rob_tag a, input rob_tag b);
		return a[TAG_W-1:0] == b[TAG_W-1:0];
	endfunction

	// Operand rule: register, then ROB, then live CDB, else wait on the tag
	function automatic void resolve(
		input  logic     busy,
		input  rob_tag   tag,
		input  lc3b_word rf_val,
		input  logic     rob_done,
		input  lc3b_word rob_val,
		output lc3b_word val,
		output rob_tag   q,
		output logic     ok
	);
		val = rf_val;
		q   = '0;
		ok  = 1'b1;
		if (busy) begin
			if (rob_done) begin
				val = rob_val;
			end else if (cdb_valid && tag_hit(cdb_tag, tag)) begin
				val = cdb_data;
			end else begin
				q  = tag;
				ok = 1'b0;
			end
		end
	endfunction

	assign opcode    = lc3b_opcode'(instr[15:12]);
	assign dest_reg  = instr[11:9];
	assign src1_reg  = instr[8:6];
	assign src2_reg  = instr[2:0];
	assign imm_form  = instr[5];
	assign imm_value = {{11{instr[4]}}, instr[4:0]};

	always_comb begin
		op_legal = 1'b1;
		rs_op    = alu_add;
		case (opcode)
			op_add:  rs_op = alu_add;
			op_and:  rs_op = alu_and;
			op_not:  rs_op = alu_not;
			default: op_legal = 1'b0;
		endcase
	end

	// Lowest free station
	always_comb begin
		free_found = 1'b0;
		free_sel   = '0;
		for (int i = 0; i < RS_COUNT; i++) begin
			if (!rs_busy[i] && !free_found) begin
				free_found = 1'b1;
				free_sel   = rs_index'(i);
			end
		end
	end

	assign issue_stall = rob_full | ~free_found;
	assign issue_fire  = instr_is_new & ~issue_stall & op_legal;

	always_comb begin
		resolve(src1_busy, src1_tag, src1_value, src1_done, src1_result,
			rs_vj, rs_qj, rs_valid_j);
		if (opcode == op_not) begin
			// NOT has a single source
			rs_vk      = '0;
			rs_qk      = '0;
			rs_valid_k = 1'b1;
		end else if (imm_form) begin
			rs_vk      = imm_value;
			rs_qk      = '0;
			rs_valid_k = 1'b1;
		end else begin
			resolve(src2_busy, src2_tag, src2_value, src2_done, src2_result,
				rs_vk, rs_qk, rs_valid_k);
		end
	end

	assign rs_write     = issue_fire;
	assign rs_sel       = free_sel;
	assign rs_dest_tag  = rob_tail_tag;
	assign rob_alloc    = issue_fire;
	assign rob_dest_reg = dest_reg;
	assign rename_valid = issue_fire;
	assign rename_reg   = dest_reg;
	assign rename_tag   = rob_tail_tag;

endmodule

`default_nettype wire

/* hw/res_station_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module res_station_pool #(
	parameter int RS_COUNT = ooo_pkg::NUM_RS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rs_write,
	input  ooo_pkg::rs_index       rs_sel,
	input  lc3b_isa_pkg::alu_op_e  rs_op,
	input  lc3b_isa_pkg::lc3b_word rs_vj,
	input  lc3b_isa_pkg::lc3b_word rs_vk,
	input  ooo_pkg::rob_tag        rs_qj,
	input  ooo_pkg::rob_tag        rs_qk,
	input  logic                  rs_valid_j,
	input  logic                  rs_valid_k,
	input  ooo_pkg::rob_tag        rs_dest_tag,
	output logic [RS_COUNT-1:0]   rs_busy,
	input  logic                  cdb_valid,
	input  ooo_pkg::rob_tag        cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data,
	output logic                  ex_start,
	output lc3b_isa_pkg::alu_op_e  ex_op,
	output lc3b_isa_pkg::lc3b_word ex_a,
	output lc3b_isa_pkg::lc3b_word ex_b,
	output ooo_pkg::rob_tag        ex_tag
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	logic [RS_COUNT-1:0] busy;
	logic [RS_COUNT-1:0] valid_j;
	logic [RS_COUNT-1:0] valid_k;
	logic [RS_COUNT-1:0] ready;
	logic [RS_COUNT-1:0] take_j;
	logic [RS_COUNT-1:0] take_k;
	logic [RS_COUNT-1:0] load;
	logic [RS_COUNT-1:0] issue_out;
	alu_op_e  op   [RS_COUNT];
	lc3b_word vj   [RS_COUNT];
	lc3b_word vk   [RS_COUNT];
	rob_tag   qj   [RS_COUNT];
	rob_tag   qk   [RS_COUNT];
	rob_tag   dest [RS_COUNT];
	logic     disp_found;
	rs_index  disp_sel;

	// Ready from registered state only, so a fresh capture waits a cycle
	assign ready   = busy & valid_j & valid_k;
	assign rs_busy = busy;

	always_comb begin
		disp_found = 1'b0;
		disp_sel   = '0;
		for (int i = 0; i < RS_COUNT; i++) begin
			if (ready[i] && !disp_found) begin
				disp_found = 1'b1;
				disp_sel   = rs_index'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < RS_COUNT; i++) begin
			take_j[i]    = busy[i] & ~valid_j[i] & cdb_valid & (qj[i] == cdb_tag);
			take_k[i]    = busy[i] & ~valid_k[i] & cdb_valid & (qk[i] == cdb_tag);
			load[i]      = rs_write & (rs_sel == rs_index'(i));
			issue_out[i] = disp_found & (disp_sel == rs_index'(i));
		end
	end

	assign ex_start = disp_found;
	assign ex_op    = op[disp_sel];
	assign ex_a     = vj[disp_sel];
	assign ex_b     = vk[disp_sel];
	assign ex_tag   = dest[disp_sel];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= '0;
			valid_j <= '0;
			valid_k <= '0;
		end else begin
			for (int i = 0; i < RS_COUNT; i++) begin
				if (issue_out[i]) begin
					busy[i] <= 1'b0;
				end
				if (take_j[i]) begin
					valid_j[i] <= 1'b1;
				end
				if (take_k[i]) begin
					valid_k[i] <= 1'b1;
				end
				if (load[i]) begin
					busy[i]    <= 1'b1;
					valid_j[i] <= rs_valid_j;
					valid_k[i] <= rs_valid_k;
				end
			end
		end
	end

	// Station payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < RS_COUNT; i++) begin
			if (take_j[i]) begin
				vj[i] <= cdb_data;
			end
			if (take_k[i]) begin
				vk[i] <= cdb_data;
			end
			if (load[i]) begin
				op[i]   <= rs_op;
				vj[i]   <= rs_vj;
				vk[i]   <= rs_vk;
				qj[i]   <= rs_qj;
				qk[i]   <= rs_qk;
				dest[i] <= rs_dest_tag;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_start,
	input  lc3b_isa_pkg::alu_op_e  ex_op,
	input  lc3b_isa_pkg::lc3b_word ex_a,
	input  lc3b_isa_pkg::lc3b_word ex_b,
	input  ooo_pkg::rob_tag        ex_tag,
	output logic                  cdb_valid,
	output ooo_pkg::rob_tag        cdb_tag,
	output lc3b_isa_pkg::lc3b_word cdb_data
);

	import lc3b_isa_pkg::*;

	lc3b_word result;

	always_comb begin
		case (ex_op)
			alu_add: result = ex_a + ex_b;
			alu_and: result = ex_a & ex_b;
			alu_not: result = ~ex_a;
			default: result = '0;
		endcase
	end

	// One cycle from dispatch to broadcast
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= ex_start;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_start) begin
			cdb_tag  <= ex_tag;
			cdb_data <= result;
		end
	end

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rob_alloc,
	input  lc3b_isa_pkg::lc3b_reg  rob_dest_reg,
	output logic                  rob_full,
	output ooo_pkg::rob_tag        rob_tail_tag,
	input  ooo_pkg::rob_tag        src1_tag,
	input  ooo_pkg::rob_tag        src2_tag,
	output logic                  src1_done,
	output lc3b_isa_pkg::lc3b_word src1_result,
	output logic                  src2_done,
	output lc3b_isa_pkg::lc3b_word src2_result,
	input  logic                  cdb_valid,
	input  ooo_pkg::rob_tag        cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data,
	output logic                  commit_valid,
	output lc3b_isa_pkg::lc3b_reg  commit_reg,
	output ooo_pkg::rob_tag        commit_tag,
	output lc3b_isa_pkg::lc3b_word commit_value
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	logic [ROB_DEPTH-1:0] done;
	lc3b_word             result [ROB_DEPTH];
	lc3b_reg              dest   [ROB_DEPTH];
	rob_tag               head;
	rob_tag               tail;
	logic [CNT_W-1:0]     count;

	function automatic rob_tag wrap_inc(input rob_tag ptr);
		return (ptr == rob_tag'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign rob_full     = (count == CNT_W'(ROB_DEPTH));
	assign rob_tail_tag = tail;

	// Operand lookup for issue
	assign src1_done   = done[src1_tag];
	assign src1_result = result[src1_tag];
	assign src2_done   = done[src2_tag];
	assign src2_result = result[src2_tag];

	// Head retires once its result is in
	assign commit_valid = (count != '0) && done[head];
	assign commit_reg   = dest[head];
	assign commit_tag   = head;
	assign commit_value = result[head];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (cdb_valid) begin
				done[cdb_tag] <= 1'b1;
			end
			if (rob_alloc) begin
				done[tail] <= 1'b0;
				tail       <= wrap_inc(tail);
			end
			if (commit_valid) begin
				head <= wrap_inc(head);
			end
			count <= count + CNT_W'(rob_alloc) - CNT_W'(commit_valid);
		end
	end

	always_ff @(posedge clk) begin
		if (cdb_valid) begin
			result[cdb_tag] <= cdb_data;
		end
		if (rob_alloc) begin
			dest[tail] <= rob_dest_reg;
		end
	end

endmodule

`default_nettype wire

/* hw/regfile_tags.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_tags (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_isa_pkg::lc3b_reg  src1_reg,
	input  lc3b_isa_pkg::lc3b_reg  src2_reg,
	output lc3b_isa_pkg::lc3b_word src1_value,
	output logic                  src1_busy,
	output ooo_pkg::rob_tag        src1_tag,
	output lc3b_isa_pkg::lc3b_word src2_value,
	output logic                  src2_busy,
	output ooo_pkg::rob_tag        src2_tag,
	input  logic                  rename_valid,
	input  lc3b_isa_pkg::lc3b_reg  rename_reg,
	input  ooo_pkg::rob_tag        rename_tag,
	input  logic                  commit_valid,
	input  lc3b_isa_pkg::lc3b_reg  commit_reg,
	input  ooo_pkg::rob_tag        commit_tag,
	input  lc3b_isa_pkg::lc3b_word commit_value
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	lc3b_word   value [8];
	logic [7:0] busy;
	rob_tag     owner [8];

	assign src1_value = value[src1_reg];
	assign src1_busy  = busy[src1_reg];
	assign src1_tag   = owner[src1_reg];
	assign src2_value = value[src2_reg];
	assign src2_busy  = busy[src2_reg];
	assign src2_tag   = owner[src2_reg];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			for (int i = 0; i < 8; i++) begin
				value[i] <= '0;
				owner[i] <= '0;
			end
		end else begin
			if (commit_valid) begin
				value[commit_reg] <= commit_value;
				// Only the youngest writer releases the register
				if (owner[commit_reg] == commit_tag) begin
					busy[commit_reg] <= 1'b0;
				end
			end
			// Rename comes last so it wins on the same register
			if (rename_valid) begin
				busy[rename_reg]  <= 1'b1;
				owner[rename_reg] <= rename_tag;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/tomasulo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
	parameter int ROB_DEPTH = 8,
	parameter int RS_COUNT  = ooo_pkg::NUM_RS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_isa_pkg::lc3b_word instr,
	input  logic                  instr_is_new,
	output logic                  issue_stall,
	output logic                  commit_valid,
	output lc3b_isa_pkg::lc3b_reg  commit_reg,
	output lc3b_isa_pkg::lc3b_word commit_value
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	// Register file lookup
	lc3b_reg  src1_reg;
	lc3b_reg  src2_reg;
	lc3b_word src1_value;
	lc3b_word src2_value;
	logic     src1_busy;
	logic     src2_busy;
	rob_tag   src1_tag;
	rob_tag   src2_tag;

	// ROB lookup and allocation
	logic     src1_done;
	logic     src2_done;
	lc3b_word src1_result;
	lc3b_word src2_result;
	logic     rob_full;
	rob_tag   rob_tail_tag;
	logic     rob_alloc;
	lc3b_reg  rob_dest_reg;
	rob_tag   commit_tag;

	logic     rename_valid;
	lc3b_reg  rename_reg;
	rob_tag   rename_tag;

	// Station write
	logic [RS_COUNT-1:0] rs_busy;
	logic     rs_write;
	rs_index  rs_sel;
	alu_op_e  rs_op;
	lc3b_word rs_vj;
	lc3b_word rs_vk;
	rob_tag   rs_qj;
	rob_tag   rs_qk;
	logic     rs_valid_j;
	logic     rs_valid_k;
	rob_tag   rs_dest_tag;

	// Dispatch and CDB
	logic     ex_start;
	alu_op_e  ex_op;
	lc3b_word ex_a;
	lc3b_word ex_b;
	rob_tag   ex_tag;
	logic     cdb_valid;
	rob_tag   cdb_tag;
	lc3b_word cdb_data;

	issue_control #(
		.ROB_DEPTH(ROB_DEPTH),
		.RS_COUNT (RS_COUNT)
	) u_issue (.*);

	res_station_pool #(
		.RS_COUNT(RS_COUNT)
	) u_rs_pool (.*);

	alu_unit u_alu (.*);

	reorder_buffer #(
		.ROB_DEPTH(ROB_DEPTH)
	) u_rob (.*);

	regfile_tags u_regfile (.*);

endmodule

`default_nettype wire

/* verif/tb_tomasulo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_core;

	import lc3b_isa_pkg::*;

	localparam int ROB_DEPTH   = 8;
	localparam int RS_COUNT    = 3;
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 1000;

	// LC-3b operate opcodes
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_not = 4'b1001;

	logic     clk;
	logic     rst_n;
	lc3b_word instr;
	logic     instr_is_new;
	logic     issue_stall;
	logic     commit_valid;
	lc3b_reg  commit_reg;
	lc3b_word commit_value;

	lc3b_word    ref_regs [8];
	lc3b_reg     exp_reg_q [$];
	lc3b_word    exp_val_q [$];
	lc3b_reg     exp_reg;
	lc3b_word    exp_val;
	lc3b_word    same_dest_val;
	string       test_name;
	int          issued_count;
	int          committed_count;
	int          check_errors;
	int          timeout_errors;
	logic        timed_out;
	logic        stall_seen;
	logic        rob_filled;
	integer      seed;
	logic [31:0] rnd;

	tomasulo_core #(
		.ROB_DEPTH(ROB_DEPTH),
		.RS_COUNT (RS_COUNT)
	) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_is_new(instr_is_new),
		.issue_stall (issue_stall),
		.commit_valid(commit_valid),
		.commit_reg  (commit_reg),
		.commit_value(commit_value)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic lc3b_word enc_reg(input logic [3:0] opc, input lc3b_reg dr,
		input lc3b_reg sr1, input lc3b_reg sr2);
		return {opc, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word enc_imm(input logic [3:0] opc, input lc3b_reg dr,
		input lc3b_reg sr1, input logic [4:0] imm5);
		return {opc, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic lc3b_word enc_not(input lc3b_reg dr, input lc3b_reg sr);
		return {opc_not, dr, sr, 6'b111111};
	endfunction

	function automatic lc3b_word random_instr(input logic [31:0] r);
		lc3b_word word;
		case (r[30:29])
			2'd1: word = r[3] ? enc_imm(opc_and, r[6:4], r[9:7], r[17:13])
				: enc_reg(opc_and, r[6:4], r[9:7], r[12:10]);
			2'd2: word = enc_not(r[6:4], r[9:7]);
			default: word = r[3] ? enc_imm(opc_add, r[6:4], r[9:7], r[17:13])
				: enc_reg(opc_add, r[6:4], r[9:7], r[12:10]);
		endcase
		return word;
	endfunction

	// ISA semantics, applied in program order at issue
	function automatic void model_issue(input lc3b_word word);
		lc3b_reg  dr;
		lc3b_reg  sr1;
		lc3b_word b;
		lc3b_word v;
		dr  = word[11:9];
		sr1 = word[8:6];
		b   = word[5] ? {{11{word[4]}}, word[4:0]} : ref_regs[word[2:0]];
		case (word[15:12])
			opc_add: v = ref_regs[sr1] + b;
			opc_and: v = ref_regs[sr1] & b;
			default: v = ~ref_regs[sr1];
		endcase
		ref_regs[dr] = v;
		exp_reg_q.push_back(dr);
		exp_val_q.push_back(v);
	endfunction

	task automatic issue_instr(input lc3b_word word);
		int waited;
		waited = 0;
		if (timed_out) begin
			return;
		end
		@(negedge clk);
		while (issue_stall && !timed_out) begin
			instr_is_new = 1'b0;
			waited++;
			if (waited > STALL_LIMIT) begin
				$display("Timeout in %s: issue_stall stayed high for %0d cycles",
					test_name, STALL_LIMIT);
				timeout_errors++;
				timed_out = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
		if (!timed_out) begin
			instr        = word;
			instr_is_new = 1'b1;
			model_issue(word);
			issued_count++;
		end
	endtask

	task automatic end_issue();
		@(negedge clk);
		instr_is_new = 1'b0;
	endtask

	task automatic drain_commits();
		int waited;
		waited = 0;
		end_issue();
		while (exp_reg_q.size() != 0 && !timed_out) begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				$display("Timeout in %s: %0d expected commits never arrived",
					test_name, exp_reg_q.size());
				timeout_errors++;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			assert (committed_count == issued_count) else begin
				$display("** Error [%s] commit count: expected %0d, actual %0d",
					test_name, issued_count, committed_count);
				check_errors++;
			end
		end
	endtask

	// Commit strobe is stable at the falling edge, retires at the next rising edge
	always @(negedge clk) begin
		if (rst_n && commit_valid) begin
			committed_count++;
			if (exp_reg_q.size() == 0) begin
				$display("[%s] Commit to R%0d arrived with nothing outstanding",
					test_name, commit_reg);
				check_errors++;
			end else begin
				exp_reg = exp_reg_q.pop_front();
				exp_val = exp_val_q.pop_front();
				assert (commit_reg == exp_reg) else begin
					$display("** Error [%s] commit_reg: expected %0d, actual %0d",
						test_name, exp_reg, commit_reg);
					check_errors++;
				end
				assert (commit_value == exp_val) else begin
					$display("** Error [%s] commit_value: expected %h, actual %h",
						test_name, exp_val, commit_value);
					check_errors++;
				end
			end
		end
	end

	// Settled state just after each rising edge
	always @(posedge clk) begin
		#10;
		if (issue_stall) begin
			stall_seen = 1'b1;
		end
		if ((issued_count - committed_count) >= ROB_DEPTH) begin
			rob_filled = 1'b1;
		end
		if (issued_count == 0) begin
			assert (!commit_valid && !issue_stall) else begin
				$display("** Error [%s] idle outputs: expected 0 0, actual %b %b",
					test_name, commit_valid, issue_stall);
				check_errors++;
			end
		end
		assert ((issued_count - committed_count) < ROB_DEPTH || issue_stall) else begin
			$display("** Error [%s] issue_stall with %0d in flight: expected 1, actual %b",
				test_name, issued_count - committed_count, issue_stall);
			check_errors++;
		end
	end

	initial begin
		rst_n           = 1'b0;
		instr           = '0;
		instr_is_new    = 1'b0;
		issued_count    = 0;
		committed_count = 0;
		check_errors    = 0;
		timeout_errors  = 0;
		timed_out       = 1'b0;
		stall_seen      = 1'b0;
		rob_filled      = 1'b0;
		same_dest_val   = '0;
		seed            = 40662;
		test_name       = "reset";
		for (int r = 0; r < 8; r++) begin
			ref_regs[r] = '0;
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);

		test_name = "independent_imm";
		issue_instr(enc_imm(opc_add, 3'd1, 3'd0, 5'd7));
		issue_instr(enc_imm(opc_add, 3'd2, 3'd0, 5'b11101));
		issue_instr(enc_imm(opc_and, 3'd6, 3'd7, 5'b01111));
		issue_instr(enc_imm(opc_add, 3'd7, 3'd0, 5'd12));
		issue_instr(enc_imm(opc_add, 3'd5, 3'd0, 5'b10000));
		drain_commits();

		// Tag wait, CDB capture and ROB lookup
		test_name = "dependent_chain";
		issue_instr(enc_reg(opc_add, 3'd0, 3'd1, 3'd2));
		issue_instr(enc_reg(opc_and, 3'd4, 3'd0, 3'd1));
		issue_instr(enc_not(3'd4, 3'd4));
		drain_commits();

		test_name  = "stall_burst";
		stall_seen = 1'b0;
		for (int n = 0; n < 10; n++) begin
			issue_instr(enc_imm(opc_add, 3'd1, 3'd1, 5'd1));
		end
		drain_commits();
		if (!timed_out) begin
			assert (stall_seen) else begin
				$display("[%s] issue_stall never rose during the dependent burst", test_name);
				check_errors++;
			end
		end

		// Short chain parks an old entry in the last station while ready work fills the ROB
		rob_filled = 1'b0;
		for (int n = 0; n < 3; n++) begin
			issue_instr(enc_imm(opc_add, 3'd1, 3'd1, 5'd1));
		end
		for (int n = 0; n < 12; n++) begin
			issue_instr(enc_imm(opc_add, lc3b_reg'(2 + n % 6), 3'd0, 5'(n)));
		end
		drain_commits();
		if (!timed_out) begin
			assert (rob_filled) else begin
				$display("[%s] in-flight count never reached the ROB depth", test_name);
				check_errors++;
			end
		end

		test_name = "same_dest";
		issue_instr(enc_imm(opc_add, 3'd3, 3'd0, 5'd5));
		issue_instr(enc_imm(opc_add, 3'd3, 3'd0, 5'b11110));
		same_dest_val = ref_regs[3];
		issue_instr(enc_imm(opc_add, 3'd5, 3'd3, 5'd0));
		drain_commits();
		@(negedge clk);
		if (!timed_out) begin
			assert (UUT.u_regfile.value[3] == same_dest_val) else begin
				$display("** Error [%s] R3 after drain: expected %h, actual %h",
					test_name, same_dest_val, UUT.u_regfile.value[3]);
				check_errors++;
			end
		end

		test_name = "random_program";
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			issue_instr(random_instr(rnd));
			if (rnd[21:19] == 3'd0) begin
				end_issue();
			end
		end
		drain_commits();

		end_issue();
		$display("Error counts: %0d check, %0d timeout (%0d issued, %0d committed)",
			check_errors, timeout_errors, issued_count, committed_count);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/lc3b_isa_pkg.sv
hw/ooo_pkg.sv
hw/issue_control.sv
hw/res_station_pool.sv
hw/alu_unit.sv
hw/reorder_buffer.sv
hw/regfile_tags.sv
hw/tomasulo_core.sv
verif/tb_tomasulo_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Tomasulo core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found on PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_tomasulo_core -f verilog.f -o sim_tomasulo
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output="$(./obj_dir/sim_tomasulo)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
